/* files.f */
logic/issue_pkg.sv
logic/iq_slot_if.sv
logic/issue_slot.sv
logic/slot_select.sv
logic/issue_control.sv
logic/issue_queue.sv
verif/tb_clock.sv
verif/issue_checker.sv
verif/issue_queue_sva.sv
verif/issue_queue_tb.sv

/* logic/iq_slot_if.sv */
`default_nettype none

interface iq_slot_if import issue_pkg::*; ();

  // Written by the control into the slots
  logic      [IQ_SIZE-1:0] load;
  micro_op_t [IQ_SIZE-1:0] slot_uop_in;
  logic      [IQ_SIZE-1:0] clear;

  // Slot state seen by the control and the selectors
  micro_op_t [IQ_SIZE-1:0] slot_uop;
  logic      [IQ_SIZE-1:0] free;
  logic      [IQ_SIZE-1:0] ready;

  modport control (
    output load,
    output slot_uop_in,
    output clear,
    input  slot_uop,
    input  free,
    input  ready
  );

  modport slots (
    input  load,
    input  slot_uop_in,
    input  clear,
    output slot_uop,
    output free,
    output ready
  );

endinterface

`default_nettype wire

/* logic/issue_control.sv */
`default_nettype none

module issue_control import issue_pkg::*; (
  input  wire logic                                   clock,
  input  wire logic                                   reset,

  input  wire micro_op_t [DISPATCH_WIDTH-1:0]         dispatch_uop,
  input  wire logic      [DISPATCH_WIDTH-1:0][IQ_SIZE-1:0] alloc_bus,
  input  wire logic      [ISSUE_WIDTH-1:0][IQ_SIZE-1:0]    issue_bus,
  input  wire logic      [ISSUE_WIDTH-1:0]            ex_busy,

  iq_slot_if.control                                  slots,

  output logic           [DISPATCH_WIDTH-1:0]         alloc_enable,
  output logic           [ISSUE_WIDTH-1:0]            issue_enable,
  output micro_op_t      [ISSUE_WIDTH-1:0]            issue_uop,
  output logic                                        iq_full
);

  slot_count_t free_count;
  slot_count_t load_count;
  slot_count_t clear_count;
  slot_count_t next_free_count;

  // Only valid dispatch positions take a free slot
  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      alloc_enable[i] = dispatch_uop[i].valid;
    end
  end

  assign issue_enable = ~ex_busy;

  // Dispatch to slot routing
  always_comb begin
    slots.load        = '0;
    slots.slot_uop_in = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      for (int j = 0; j < IQ_SIZE; j++) begin
        if (alloc_bus[i][j]) begin
          slots.load[j]        = 1'b1;
          slots.slot_uop_in[j] = dispatch_uop[i];
        end
      end
    end
  end

  // A lane without a grant shows valid low
  always_comb begin
    slots.clear = '0;
    issue_uop   = '0;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      for (int j = 0; j < IQ_SIZE; j++) begin
        if (issue_bus[i][j]) begin
          issue_uop[i]   = slots.slot_uop[j];
          slots.clear[j] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    load_count  = '0;
    clear_count = '0;
    for (int j = 0; j < IQ_SIZE; j++) begin
      load_count  = load_count + slot_count_t'(slots.load[j]);
      clear_count = clear_count + slot_count_t'(slots.clear[j]);
    end
  end

  assign next_free_count = free_count - load_count + clear_count;

  // Full when a whole dispatch group might not fit after this edge
  always_ff @(posedge clock) begin
    if (reset) begin
      free_count <= slot_count_t'(IQ_SIZE);
      iq_full    <= 1'b0;
    end else begin
      free_count <= next_free_count;
      iq_full    <= next_free_count < slot_count_t'(DISPATCH_WIDTH);
    end
  end

endmodule

`default_nettype wire

/* logic/issue_pkg.sv */
`default_nettype none

package issue_pkg;

  // Queue geometry
  localparam int IQ_SIZE        = 8;
  localparam int DISPATCH_WIDTH = 2;
  // Number of execution lanes and of CTB lanes
  localparam int ISSUE_WIDTH    = 2;

  // Tag and field widths
  localparam int PRF_INDEX_SIZE  = 6;
  localparam int ROB_TAG_SIZE    = 6;
  localparam int OPCODE_SIZE     = 8;
  localparam int SLOT_COUNT_SIZE = $clog2(IQ_SIZE + 1);

  // Count of slots from 0 to IQ_SIZE inclusive
  typedef logic [SLOT_COUNT_SIZE-1:0] slot_count_t;

  typedef logic [PRF_INDEX_SIZE-1:0] prf_index_t;

  typedef logic [ROB_TAG_SIZE-1:0] rob_tag_t;

  // A set pending flag means the source waits for a CTB broadcast of its index
  typedef struct packed {
    logic                   valid;
    rob_tag_t               rob_tag;
    prf_index_t             rd_index;
    prf_index_t             rs1_index;
    logic                   rs1_pending;
    prf_index_t             rs2_index;
    logic                   rs2_pending;
    logic [OPCODE_SIZE-1:0] opcode;
  } micro_op_t;

endpackage

`default_nettype wire

/* logic/issue_queue.sv */
`default_nettype none

module issue_queue import issue_pkg::*; (
  input  wire logic                         clock,
  input  wire logic                         reset,

  input  wire micro_op_t  [DISPATCH_WIDTH-1:0] dispatch_uop,

  // Common tag bus
  input  wire logic       [ISSUE_WIDTH-1:0] ctb_valid,
  input  wire prf_index_t [ISSUE_WIDTH-1:0] ctb_index,

  input  wire logic       [ISSUE_WIDTH-1:0] ex_busy,

  output micro_op_t       [ISSUE_WIDTH-1:0] issue_uop,
  output logic                              iq_full
);

  iq_slot_if slot_bus ();

  logic [DISPATCH_WIDTH-1:0][IQ_SIZE-1:0] alloc_bus;
  logic [ISSUE_WIDTH-1:0][IQ_SIZE-1:0]    issue_bus;
  logic [DISPATCH_WIDTH-1:0]              alloc_enable;
  logic [ISSUE_WIDTH-1:0]                 issue_enable;

  for (genvar k = 0; k < IQ_SIZE; k++) begin : g_slot
    issue_slot slot (
      .clock     (clock),
      .reset     (reset),
      .ctb_valid (ctb_valid),
      .ctb_index (ctb_index),
      .load      (slot_bus.load[k]),
      .uop_in    (slot_bus.slot_uop_in[k]),
      .clear     (slot_bus.clear[k]),
      .uop       (slot_bus.slot_uop[k]),
      .ready     (slot_bus.ready[k]),
      .free      (slot_bus.free[k])
    );
  end

  // Allocation picks free slots for the dispatch positions
  slot_select #(
    .GRANTS (DISPATCH_WIDTH)
  ) alloc_select (
    .request   (slot_bus.free),
    .enable    (alloc_enable),
    .grant_bus (alloc_bus),
    .grant     ()
  );

  // Issue picks ready slots for the lanes that are not busy
  slot_select #(
    .GRANTS (ISSUE_WIDTH)
  ) issue_select (
    .request   (slot_bus.ready),
    .enable    (issue_enable),
    .grant_bus (issue_bus),
    .grant     ()
  );

  issue_control control0 (
    .clock        (clock),
    .reset        (reset),
    .dispatch_uop (dispatch_uop),
    .alloc_bus    (alloc_bus),
    .issue_bus    (issue_bus),
    .ex_busy      (ex_busy),
    .slots        (slot_bus.control),
    .alloc_enable (alloc_enable),
    .issue_enable (issue_enable),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full)
  );

endmodule

`default_nettype wire

/* logic/issue_slot.sv */
`default_nettype none

module issue_slot import issue_pkg::*; (
  input  wire logic                         clock,
  input  wire logic                         reset,

  // Common tag bus
  input  wire logic       [ISSUE_WIDTH-1:0] ctb_valid,
  input  wire prf_index_t [ISSUE_WIDTH-1:0] ctb_index,

  input  wire logic                         load,
  input  wire micro_op_t                    uop_in,
  input  wire logic                         clear,

  output micro_op_t                         uop,
  output logic                              ready,
  output logic                              free
);

  logic      valid_q;
  micro_op_t payload_q;
  micro_op_t base_uop;
  micro_op_t next_uop;
  logic      rs1_woken;
  logic      rs2_woken;

  // Wakeup looks at the incoming micro-op in its load cycle
  always_comb begin
    base_uop  = load ? uop_in : uop;
    rs1_woken = 1'b0;
    rs2_woken = 1'b0;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      if (ctb_valid[i] && (ctb_index[i] == base_uop.rs1_index)) begin
        rs1_woken = 1'b1;
      end
      if (ctb_valid[i] && (ctb_index[i] == base_uop.rs2_index)) begin
        rs2_woken = 1'b1;
      end
    end
    next_uop             = base_uop;
    next_uop.rs1_pending = base_uop.rs1_pending & ~rs1_woken;
    next_uop.rs2_pending = base_uop.rs2_pending & ~rs2_woken;
  end

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= uop_in.valid;
    end
  end

  always_ff @(posedge clock) begin
    payload_q <= next_uop;
  end

  always_comb begin
    uop       = payload_q;
    uop.valid = valid_q;
  end

  assign ready = valid_q & ~payload_q.rs1_pending & ~payload_q.rs2_pending;
  assign free  = ~valid_q;

endmodule

`default_nettype wire

/* logic/slot_select.sv */
`default_nettype none

module slot_select import issue_pkg::*; #(
  parameter int GRANTS = 2
) (
  input  wire logic [IQ_SIZE-1:0]             request,
  input  wire logic [GRANTS-1:0]              enable,
  output logic      [GRANTS-1:0][IQ_SIZE-1:0] grant_bus,
  output logic      [IQ_SIZE-1:0]             grant
);

  // Each enabled grant takes the lowest request still left.
  // A disabled grant leaves the requests to the grants after it
  always_comb begin
    logic [IQ_SIZE-1:0] remaining;
    remaining = request;
    grant_bus = '0;
    for (int k = 0; k < GRANTS; k++) begin
      if (enable[k]) begin
        // Isolate the lowest set bit
        grant_bus[k] = remaining & (~remaining + IQ_SIZE'(1));
        remaining    = remaining & ~grant_bus[k];
      end
    end
  end

  always_comb begin
    grant = '0;
    for (int k = 0; k < GRANTS; k++) begin
      grant = grant | grant_bus[k];
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module issue_queue_tb -f files.f -o issue_queue_sim &&
./obj_dir/issue_queue_sim | tee sim.log &&
grep -q "All checks passed" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* verif/issue_checker.sv */
`default_nettype none

module issue_checker import issue_pkg::*; (
  input  wire logic                         clock,
  input  wire logic                         reset,
  input  wire micro_op_t  [DISPATCH_WIDTH-1:0] dispatch_uop,
  input  wire logic       [ISSUE_WIDTH-1:0] ctb_valid,
  input  wire prf_index_t [ISSUE_WIDTH-1:0] ctb_index,
  input  wire logic       [ISSUE_WIDTH-1:0] ex_busy,
  input  wire micro_op_t  [ISSUE_WIDTH-1:0] issue_uop,
  input  wire logic                         iq_full,
  input  var  int                           test_num,
  output int                                occupancy,
  output int                                check_count,
  output int                                error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TAGS = 2 ** ROB_TAG_SIZE;

  // Tag state is 0 unused, 1 waiting in the queue, 2 issued
  int        state   [TAGS];
  micro_op_t sent_uop[TAGS];
  int        wake_at [TAGS][2];
  int        cycle;
  int        last_test;
  int        test_checks;
  int        test_errors;

  function automatic string test_name(input int num);
    case (num)
      1:       return "direct_issue";
      2:       return "wakeup";
      3:       return "busy_lanes";
      4:       return "full_accounting";
      default: return "idle";
    endcase
  endfunction

  // Issued payload is the dispatched one with both sources woken
  function automatic micro_op_t expected_uop(input int tag);
    micro_op_t op;
    op             = sent_uop[tag];
    op.valid       = 1'b1;
    op.rs1_pending = 1'b0;
    op.rs2_pending = 1'b0;
    return op;
  endfunction

  function automatic logic expected_full(input int occupied);
    return occupied > IQ_SIZE - DISPATCH_WIDTH;
  endfunction

  // First cycle a tag may issue or -1 while a source still waits
  function automatic int ready_cycle(input int tag);
    if (wake_at[tag][0] < 0 || wake_at[tag][1] < 0) begin
      return -1;
    end
    return (wake_at[tag][0] > wake_at[tag][1] ? wake_at[tag][0] : wake_at[tag][1]) + 1;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    test_checks++;
    if (expected !== actual) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name(test_num), what,
               expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    check_count++;
    test_checks++;
    if (!ok) begin
      $display("Error in %s: %s", test_name(test_num), what);
      error_count++;
      test_errors++;
    end
  endtask

  always @(negedge clock) begin
    int tag;
    if (reset) begin
      for (int t = 0; t < TAGS; t++) begin
        state[t] = 0;
      end
      occupancy   = 0;
      cycle       = 0;
      check_count = 0;
      error_count = 0;
      last_test   = 0;
      test_checks = 0;
      test_errors = 0;
    end else begin
      cycle++;
      if (test_num != last_test) begin
        if (last_test != 0) begin
          $display("Test %s done: %0d checks, %0d errors", test_name(last_test),
                   test_checks, test_errors);
        end
        last_test   = test_num;
        test_checks = 0;
        test_errors = 0;
      end
      // iq_full reflects the occupancy left by the previous edge
      check_value("iq_full", 64'(expected_full(occupancy)), 64'(iq_full));
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (dispatch_uop[i].valid) begin
          tag              = int'(dispatch_uop[i].rob_tag);
          state[tag]       = 1;
          sent_uop[tag]    = dispatch_uop[i];
          wake_at[tag][0]  = dispatch_uop[i].rs1_pending ? -1 : cycle;
          wake_at[tag][1]  = dispatch_uop[i].rs2_pending ? -1 : cycle;
          occupancy++;
        end
      end
      // Broadcasts in the load cycle count too
      for (int t = 0; t < TAGS; t++) begin
        for (int j = 0; j < ISSUE_WIDTH; j++) begin
          if (state[t] == 1 && ctb_valid[j]) begin
            if (wake_at[t][0] < 0 && ctb_index[j] == sent_uop[t].rs1_index) begin
              wake_at[t][0] = cycle;
            end
            if (wake_at[t][1] < 0 && ctb_index[j] == sent_uop[t].rs2_index) begin
              wake_at[t][1] = cycle;
            end
          end
        end
      end
      for (int i = 0; i < ISSUE_WIDTH; i++) begin
        if (issue_uop[i].valid) begin
          tag = int'(issue_uop[i].rob_tag);
          check_true(!ex_busy[i], $sformatf("lane %0d issued while busy", i));
          check_true(state[tag] == 1,
                     $sformatf("rob_tag %0d issued but was not waiting in the queue", tag));
          if (state[tag] == 1) begin
            check_value($sformatf("lane %0d uop", i), 64'(expected_uop(tag)),
                        64'(issue_uop[i]));
            check_true(ready_cycle(tag) >= 0 && cycle >= ready_cycle(tag),
                       $sformatf("rob_tag %0d issued before its sources were woken", tag));
            if (test_num == 1) begin
              check_value($sformatf("issue cycle of rob_tag %0d", tag),
                          64'(ready_cycle(tag)), 64'(cycle));
            end
            state[tag] = 2;
            occupancy--;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/issue_queue_sva.sv */
`default_nettype none

module issue_queue_sva import issue_pkg::*; (
  input wire logic                              clock,
  input wire logic                              reset,
  input wire micro_op_t [DISPATCH_WIDTH-1:0]    dispatch_uop,
  input wire logic      [ISSUE_WIDTH-1:0]       ex_busy,
  input wire micro_op_t [ISSUE_WIDTH-1:0]       issue_uop,
  input wire logic                              iq_full
);
  timeunit 1ns;
  timeprecision 1ps;

  for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_dispatch
    dispatch_while_full: assert property (
      @(posedge clock) disable iff (reset) iq_full |-> !dispatch_uop[i].valid
    ) else $error("Dispatch position %0d is valid while iq_full is high", i);
  end

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
    issue_on_busy_lane: assert property (
      @(posedge clock) disable iff (reset) ex_busy[i] |-> !issue_uop[i].valid
    ) else $error("Lane %0d issues while ex_busy is high", i);
  end

  same_tag_on_two_lanes: assert property (
    @(posedge clock) disable iff (reset)
      issue_uop[0].valid && issue_uop[1].valid |-> issue_uop[0].rob_tag != issue_uop[1].rob_tag
  ) else $error("Both lanes carry the same rob_tag");

endmodule

bind issue_queue issue_queue_sva sva0 (
  .clock        (clock),
  .reset        (reset),
  .dispatch_uop (dispatch_uop),
  .ex_busy      (ex_busy),
  .issue_uop    (issue_uop),
  .iq_full      (iq_full)
);

`default_nettype wire

/* verif/issue_queue_tb.sv */
`default_nettype none

module issue_queue_tb import issue_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES  = 10;
  localparam int DIRECT_CYCLES = 6;
  localparam int WAKE_CYCLES   = 10;
  localparam int BUSY_CYCLES   = 10;
  localparam int FILL_CYCLES   = 8;
  localparam int DRAIN_CYCLES  = 30;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECT_CYCLES + WAKE_CYCLES + BUSY_CYCLES
                                + FILL_CYCLES + 4 * DRAIN_CYCLES + 20;

  logic                            clock;
  logic                            reset;
  micro_op_t  [DISPATCH_WIDTH-1:0] dispatch_uop;
  logic       [ISSUE_WIDTH-1:0]    ctb_valid;
  prf_index_t [ISSUE_WIDTH-1:0]    ctb_index;
  logic       [ISSUE_WIDTH-1:0]    ex_busy;
  micro_op_t  [ISSUE_WIDTH-1:0]    issue_uop;
  logic                            iq_full;
  int                              test_num;
  int                              occupancy;
  int                              check_count;
  int                              error_count;
  int                              next_tag;
  int                              cycle_count = 0;
  logic       [16:0]               lfsr_state;
  prf_index_t                      wake_queue[$];

  tb_clock #(.PERIOD(40), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
    .clock (clock),
    .reset (reset)
  );

  issue_queue dut0 (
    .clock        (clock),
    .reset        (reset),
    .dispatch_uop (dispatch_uop),
    .ctb_valid    (ctb_valid),
    .ctb_index    (ctb_index),
    .ex_busy      (ex_busy),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full)
  );

  issue_checker checker0 (
    .clock        (clock),
    .reset        (reset),
    .dispatch_uop (dispatch_uop),
    .ctb_valid    (ctb_valid),
    .ctb_index    (ctb_index),
    .ex_busy      (ex_busy),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full),
    .test_num     (test_num),
    .occupancy    (occupancy),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  // Fibonacci LFSR x^17 + x^14 + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    logic        feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      feedback   = lfsr_state[16] ^ lfsr_state[13];
      lfsr_state = {lfsr_state[15:0], feedback};
      bits       = {bits[30:0], feedback};
    end
    return bits;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  // pending_mode 0 none, 1 random flags, 2 rs1 always waits
  task automatic make_uop(input int pending_mode, output micro_op_t op);
    op           = '0;
    op.valid     = 1'b1;
    op.rob_tag   = rob_tag_t'(next_tag);
    op.rd_index  = prf_index_t'(take_bits(PRF_INDEX_SIZE));
    op.rs1_index = prf_index_t'(take_bits(PRF_INDEX_SIZE));
    op.rs2_index = prf_index_t'(take_bits(PRF_INDEX_SIZE));
    op.opcode    = OPCODE_SIZE'(take_bits(OPCODE_SIZE));
    if (pending_mode != 0) begin
      op.rs1_pending = (pending_mode == 2) || 1'(take_bits(1));
      op.rs2_pending = 1'(take_bits(1));
    end
    next_tag++;
  endtask

  task automatic drive_cycle(input int count, input int pending_mode,
                             input logic [ISSUE_WIDTH-1:0] busy, input logic broadcast);
    micro_op_t op;
    dispatch_uop = '0;
    ctb_valid    = '0;
    ctb_index    = '0;
    ex_busy      = busy;
    if (!iq_full) begin
      for (int i = 0; i < count; i++) begin
        make_uop(pending_mode, op);
        dispatch_uop[i] = op;
        if (op.rs1_pending) wake_queue.push_back(op.rs1_index);
        if (op.rs2_pending) wake_queue.push_back(op.rs2_index);
      end
    end
    // A tag pushed this cycle may go out in its own load cycle
    for (int j = 0; j < ISSUE_WIDTH; j++) begin
      if (broadcast && wake_queue.size() > 0) begin
        ctb_valid[j] = 1'b1;
        ctb_index[j] = wake_queue.pop_front();
      end
    end
    next_cycle();
  endtask

  task automatic drain();
    while (occupancy != 0 || wake_queue.size() != 0) begin
      drive_cycle(0, 0, '0, 1'b1);
    end
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the queue did not drain", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    lfsr_state   = 17'd93827;
    next_tag     = 0;
    test_num     = 0;
    dispatch_uop = '0;
    ctb_valid    = '0;
    ctb_index    = '0;
    ex_busy      = '0;
    @(negedge reset);
    test_num = 1;
    repeat (DIRECT_CYCLES) drive_cycle(DISPATCH_WIDTH, 0, '0, 1'b0);
    drain();
    test_num = 2;
    repeat (WAKE_CYCLES) drive_cycle(1, 1, '0, 1'(take_bits(1)));
    drain();
    test_num = 3;
    repeat (BUSY_CYCLES) begin
      drive_cycle(1 + int'(take_bits(1)), 0, ISSUE_WIDTH'(take_bits(ISSUE_WIDTH)), 1'b0);
    end
    drain();
    // Waiting micro-ops pile up with the CTB quiet until iq_full rises
    test_num = 4;
    repeat (FILL_CYCLES) drive_cycle(1 + int'(take_bits(1)), 2, '0, 1'b0);
    drain();
    test_num = 0;
    next_cycle();
    next_cycle();
    $display("Tests 4, checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // Reset drops just after an edge as the rest of the stimulus does
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire
